//--- include/rld_params.svh
// Sizing and latency constants for the RLDRAM model.
// Included by the packages and by any module that sizes arrays or
// decodes the mode register.

`ifndef RLD_PARAMS_SVH
`define RLD_PARAMS_SVH

// Data, address and bank widths
`define RLD_DATA_W 18
`define RLD_ADDR_W 6
`define RLD_BANK_W 3

// Array geometry
`define RLD_BANKS 8
`define RLD_DEPTH 64

// Command latency pipeline
`define RLD_PIPE_LEN 10

// Read latency per configuration; WL is RL + 1 and tRC equals RL
`define RLD_CFG1_RL 4
`define RLD_CFG2_RL 6
`define RLD_CFG3_RL 8

`endif

//--- hdl/rldCmdPkg.sv
// Command and mode register types.
// Shared by the command decoder, mode register, latency pipeline
// and burst engine.

package rldCmdPkg;

    // Decoded command from csN, weN and refN
    typedef enum logic [2:0] {
        NOP,
        MRS,
        READ,
        WRITE,
        AREF
    } rldCmdE;

    // Burst length code, same encoding as MRS address bits 4:3
    typedef enum logic [1:0] {
        BURST_2 = 2'd0,
        BURST_4 = 2'd1,
        BURST_8 = 2'd2
    } rldBurstE;

    // Active mode, latencies in clock cycles
    typedef struct packed {
        logic [3:0] readLat;
        logic [3:0] writeLat;
        logic [3:0] trc;
        rldBurstE   burst;
    } rldModeT;

endpackage

//--- hdl/rldDataPkg.sv
// Data, address and request types for the RLDRAM model.
// The request struct is one slot of the command latency pipeline.

`include "rld_params.svh"

package rldDataPkg;

    typedef logic [`RLD_DATA_W-1:0] rldDataT;
    typedef logic [`RLD_ADDR_W-1:0] rldAddrT;
    typedef logic [`RLD_BANK_W-1:0] rldBankT;

    // Pending read or write, waiting out its latency
    typedef struct packed {
        logic    valid;
        logic    isRead;
        rldBankT bank;
        rldAddrT addr;
    } rldReqT;

endpackage

//--- hdl/rldIfs.sv
// Internal interfaces of the RLDRAM model.
// rldCmdIf carries the registered command, rldModeIf the active mode,
// rldBurstIf the per-beat array access from the burst engine.

interface rldCmdIf;
    rldCmdPkg::rldCmdE  cmd;
    rldDataPkg::rldBankT bank;
    rldDataPkg::rldAddrT addr;
    logic               cmdStrobe;

    modport source (output cmd, bank, addr, cmdStrobe);
    modport sink (input cmd, bank, addr, cmdStrobe);
endinterface

interface rldModeIf;
    rldCmdPkg::rldModeT mode;
    // High in the cycle an MRS is applied
    logic               modeUpdate;

    modport source (output mode, modeUpdate);
    modport sink (input mode, modeUpdate);
endinterface

interface rldBurstIf;
    logic                rdEn;
    logic                wrEn;
    rldDataPkg::rldBankT bank;
    rldDataPkg::rldAddrT wordAddr;
    rldDataPkg::rldDataT d;
    logic                dm;

    modport source (output rdEn, wrEn, bank, wordAddr, d, dm);
    modport sink (input rdEn, wrEn, bank, wordAddr, d, dm);
endinterface

//--- hdl/rldCmdCheck.sv
// Command decode and per-bank tRC check.
// Registers the decoded command onto rldCmdIf one cycle after sampling,
// and pulses trcError in that same cycle for a READ or WRITE that comes
// too soon after the last access or refresh of its bank.

`include "rld_params.svh"

module rldCmdCheck (
    input  logic                Ck,
    input  logic                rstN,
    input  logic                csN,
    input  logic                weN,
    input  logic                refN,
    input  rldDataPkg::rldAddrT addr,
    input  rldDataPkg::rldBankT bank,
    rldCmdIf.source             cmdIf,
    rldModeIf.sink              modeIf,
    output logic                trcError
);
    import rldCmdPkg::*;
    import rldDataPkg::*;

    rldCmdE     cmdNow;
    logic       isAccess;
    logic       touchesBank;
    logic [4:0] elapsed;
    // Cycles since last READ, WRITE or AREF, saturating at all ones
    logic [3:0] trcCnt [`RLD_BANKS];

    always_comb begin
        if (csN) begin
            cmdNow = NOP;
        end else begin
            case ({weN, refN})
                2'b00:   cmdNow = MRS;
                2'b01:   cmdNow = WRITE;
                2'b10:   cmdNow = AREF;
                default: cmdNow = READ;
            endcase
        end
        isAccess    = (cmdNow == READ) || (cmdNow == WRITE);
        touchesBank = isAccess || (cmdNow == AREF);
        // Counter holds edges minus one since the last bank command
        elapsed     = {1'b0, trcCnt[bank]} + 5'd1;
    end

    always_ff @(posedge Ck) begin
        if (!rstN) begin
            cmdIf.cmd       <= NOP;
            cmdIf.cmdStrobe <= 1'b0;
            trcError        <= 1'b0;
        end else begin
            cmdIf.cmd       <= cmdNow;
            cmdIf.cmdStrobe <= (cmdNow != NOP);
            // Violation is flagged only, the command still runs
            trcError        <= isAccess && (elapsed < {1'b0, modeIf.mode.trc});
        end
    end

    always_ff @(posedge Ck) begin
        cmdIf.bank <= bank;
        cmdIf.addr <= addr;
    end

    always_ff @(posedge Ck) begin
        for (int b = 0; b < `RLD_BANKS; b++) begin
            if (!rstN) begin
                trcCnt[b] <= '1;
            end else if (touchesBank && (bank == rldBankT'(b))) begin
                trcCnt[b] <= '0;
            end else if (trcCnt[b] != '1) begin
                trcCnt[b] <= trcCnt[b] + 4'd1;
            end
        end
    end

endmodule

//--- hdl/rldModeReg.sv
// Mode register.
// Loads configuration and burst length on MRS. The new mode is visible
// in the cycle the MRS sits on rldCmdIf, so commands sampled right after
// the MRS already see it.

`include "rld_params.svh"

module rldModeReg (
    input  logic     Ck,
    input  logic     rstN,
    rldCmdIf.sink    cmdIf,
    rldModeIf.source modeIf
);
    import rldCmdPkg::*;
    import rldDataPkg::*;

    rldModeT modeR;
    rldModeT modeNew;
    logic    mrsNow;

    // Address bits 2:0 select the configuration, bits 4:3 the burst length
    function automatic rldModeT decodeMode(input rldAddrT a);
        rldModeT    m;
        logic [3:0] rl;
        case (a[2:0])
            3'd2:    rl = 4'(`RLD_CFG2_RL);
            3'd3:    rl = 4'(`RLD_CFG3_RL);
            default: rl = 4'(`RLD_CFG1_RL);
        endcase
        m.readLat  = rl;
        m.writeLat = rl + 4'd1;
        m.trc      = rl;
        case (a[4:3])
            2'd1:    m.burst = BURST_4;
            2'd2:    m.burst = BURST_8;
            default: m.burst = BURST_2;
        endcase
        return m;
    endfunction

    always_comb begin
        mrsNow  = cmdIf.cmdStrobe && (cmdIf.cmd == MRS);
        modeNew = decodeMode(cmdIf.addr);
    end

    assign modeIf.modeUpdate = mrsNow;
    assign modeIf.mode       = mrsNow ? modeNew : modeR;

    always_ff @(posedge Ck) begin
        if (!rstN) begin
            // Code zero decodes to configuration 1, BL 2
            modeR <= decodeMode('0);
        end else if (mrsNow) begin
            modeR <= modeNew;
        end
    end

    // BL 8 is not offered in configuration 1
    assert property (@(posedge Ck) disable iff (!rstN)
        !((modeR.readLat == 4'(`RLD_CFG1_RL)) && (modeR.burst == BURST_8)));

endmodule

//--- hdl/rldLatencyPipe.sv
// Command latency pipeline.
// A shift register of requests moving toward slot zero by one each cycle.
// READ enters at slot RL-3, WRITE at slot WL-2, so that start fires
// early enough for the burst engine and the array register to line up.

`include "rld_params.svh"

module rldLatencyPipe (
    input  logic               Ck,
    input  logic               rstN,
    rldCmdIf.sink              cmdIf,
    rldModeIf.sink             modeIf,
    output rldDataPkg::rldReqT start
);
    import rldCmdPkg::*;
    import rldDataPkg::*;

    rldReqT     slots [`RLD_PIPE_LEN];
    rldReqT     req;
    logic       isRw;
    logic [3:0] entry;

    always_comb begin
        isRw       = cmdIf.cmdStrobe && ((cmdIf.cmd == READ) || (cmdIf.cmd == WRITE));
        req.valid  = isRw;
        req.isRead = (cmdIf.cmd == READ);
        req.bank   = cmdIf.bank;
        req.addr   = cmdIf.addr;
        if (cmdIf.cmd == READ) begin
            entry = modeIf.mode.readLat - 4'd3;
        end else begin
            entry = modeIf.mode.writeLat - 4'd2;
        end
    end

    always_ff @(posedge Ck) begin
        if (!rstN) begin
            for (int i = 0; i < `RLD_PIPE_LEN; i++) begin
                slots[i] <= '0;
            end
        end else begin
            for (int i = 0; i < `RLD_PIPE_LEN - 1; i++) begin
                slots[i] <= slots[i + 1];
            end
            slots[`RLD_PIPE_LEN - 1] <= '0;
            // New request overrides whatever shifts into its slot
            if (isRw) begin
                slots[entry] <= req;
            end
        end
    end

    assign start = slots[0];

    // A new request must not land on one already in flight
    assert property (@(posedge Ck) disable iff (!rstN)
        isRw |-> !slots[entry + 4'd1].valid);

endmodule

//--- hdl/rldBurstEngine.sv
// Read and write burst sequencing.
// On start, loads the burst-aligned word address and steps it for BL
// beats. Write data and mask are registered alongside wrEn; qValid
// trails rdEn by one cycle to match the registered array read.

module rldBurstEngine (
    input  logic                Ck,
    input  logic                rstN,
    input  rldDataPkg::rldReqT  start,
    rldModeIf.sink              modeIf,
    input  rldDataPkg::rldDataT d,
    input  logic                dm,
    rldBurstIf.source           burstIf,
    output logic                qValid
);
    import rldCmdPkg::*;
    import rldDataPkg::*;

    // Burst kinds, index into the per-kind state
    localparam int WR = 0;
    localparam int RD = 1;

    logic [1:0] kindStart;
    logic [1:0] kindEn;
    logic [2:0] beatsLeft [2];
    rldAddrT    beatAddr  [2];
    rldBankT    beatBank  [2];
    logic [2:0] lastBeat;
    rldAddrT    alignedAddr;
    rldDataT    dReg;
    logic       dmReg;

    always_comb begin
        kindStart[RD] = start.valid && start.isRead;
        kindStart[WR] = start.valid && !start.isRead;
        // Word address is command address times BL, modulo depth
        case (modeIf.mode.burst)
            BURST_4: begin
                lastBeat    = 3'd3;
                alignedAddr = start.addr << 2;
            end
            BURST_8: begin
                lastBeat    = 3'd7;
                alignedAddr = start.addr << 3;
            end
            default: begin
                lastBeat    = 3'd1;
                alignedAddr = start.addr << 1;
            end
        endcase
    end

    always_ff @(posedge Ck) begin
        for (int k = 0; k < 2; k++) begin
            if (!rstN) begin
                kindEn[k]    <= 1'b0;
                beatsLeft[k] <= '0;
            end else if (kindStart[k]) begin
                kindEn[k]    <= 1'b1;
                beatsLeft[k] <= lastBeat;
            end else if (beatsLeft[k] != '0) begin
                beatsLeft[k] <= beatsLeft[k] - 3'd1;
            end else begin
                kindEn[k] <= 1'b0;
            end
        end
    end

    always_ff @(posedge Ck) begin
        for (int k = 0; k < 2; k++) begin
            if (kindStart[k]) begin
                beatBank[k] <= start.bank;
                beatAddr[k] <= alignedAddr;
            end else if (kindEn[k]) begin
                beatAddr[k] <= beatAddr[k] + 1'b1;
            end
        end
        dReg  <= d;
        dmReg <= dm;
    end

    always_ff @(posedge Ck) begin
        if (!rstN) begin
            qValid <= 1'b0;
        end else begin
            qValid <= kindEn[RD];
        end
    end

    assign burstIf.rdEn     = kindEn[RD];
    assign burstIf.wrEn     = kindEn[WR];
    assign burstIf.bank     = kindEn[RD] ? beatBank[RD] : beatBank[WR];
    assign burstIf.wordAddr = kindEn[RD] ? beatAddr[RD] : beatAddr[WR];
    assign burstIf.d        = dReg;
    assign burstIf.dm       = dmReg;

    // A burst may only restart on its last beat
    for (genvar k = 0; k < 2; k++) begin : gNoInterrupt
        assert property (@(posedge Ck) disable iff (!rstN)
            kindStart[k] |-> !(kindEn[k] && (beatsLeft[k] != '0)));
    end

    // Read and write share one array address
    assert property (@(posedge Ck) disable iff (!rstN) kindEn != 2'b11);

    // BL must not change under a running burst
    assert property (@(posedge Ck) disable iff (!rstN)
        modeIf.modeUpdate |-> (kindEn == 2'b00));

endmodule

//--- hdl/rldBankArray.sv
// Bank memories.
// Eight banks of 64 words. Writes land when wrEn is high and dm low;
// reads are registered onto q, which returns to zero between bursts.

`include "rld_params.svh"

module rldBankArray (
    input  logic                Ck,
    input  logic                rstN,
    rldBurstIf.sink             burstIf,
    output rldDataPkg::rldDataT q
);
    import rldDataPkg::*;

    rldDataT mem [`RLD_BANKS][`RLD_DEPTH];

    // Masked words keep their old contents
    always_ff @(posedge Ck) begin
        if (burstIf.wrEn && !burstIf.dm) begin
            mem[burstIf.bank][burstIf.wordAddr] <= burstIf.d;
        end
    end

    always_ff @(posedge Ck) begin
        if (!rstN) begin
            q <= '0;
        end else if (burstIf.rdEn) begin
            q <= mem[burstIf.bank][burstIf.wordAddr];
        end else begin
            q <= '0;
        end
    end

endmodule

//--- hdl/rldTop.sv
// RLDRAM model top level.
// Separate d and q ports, single data rate. Commands are sampled on
// every rising edge of Ck; q is valid while qValid is high and
// trcError pulses one cycle after a READ or WRITE that breaks tRC.

module rldTop (
    input  logic                Ck,
    input  logic                rstN,
    input  logic                csN,
    input  logic                weN,
    input  logic                refN,
    input  rldDataPkg::rldAddrT addr,
    input  rldDataPkg::rldBankT bank,
    input  rldDataPkg::rldDataT d,
    input  logic                dm,
    output rldDataPkg::rldDataT q,
    output logic                qValid,
    output logic                trcError
);
    import rldDataPkg::*;

    rldCmdIf   cmdIf ();
    rldModeIf  modeIf ();
    rldBurstIf burstIf ();
    rldReqT    start;

    rldCmdCheck i_rldCmdCheck (
        .Ck       (Ck),
        .rstN     (rstN),
        .csN      (csN),
        .weN      (weN),
        .refN     (refN),
        .addr     (addr),
        .bank     (bank),
        .cmdIf    (cmdIf.source),
        .modeIf   (modeIf.sink),
        .trcError (trcError)
    );

    rldModeReg i_rldModeReg (
        .Ck     (Ck),
        .rstN   (rstN),
        .cmdIf  (cmdIf.sink),
        .modeIf (modeIf.source)
    );

    rldLatencyPipe i_rldLatencyPipe (
        .Ck     (Ck),
        .rstN   (rstN),
        .cmdIf  (cmdIf.sink),
        .modeIf (modeIf.sink),
        .start  (start)
    );

    rldBurstEngine i_rldBurstEngine (
        .Ck      (Ck),
        .rstN    (rstN),
        .start   (start),
        .modeIf  (modeIf.sink),
        .d       (d),
        .dm      (dm),
        .burstIf (burstIf.source),
        .qValid  (qValid)
    );

    rldBankArray i_rldBankArray (
        .Ck      (Ck),
        .rstN    (rstN),
        .burstIf (burstIf.sink),
        .q       (q)
    );

endmodule

//--- tb/rldTb.sv
// Testbench for the RLDRAM model.
// Replays tb/rldGolden.txt one line per clock cycle. Each line drives the
// command strobes and write data, then q, qValid and trcError are compared
// with the expected columns just before the next rising edge.

`include "rld_params.svh"

module rldTb;
    timeunit 1ns;
    timeprecision 100ps;

    import rldDataPkg::*;

    localparam int numCols   = 11;
    localparam int maxLines  = 64;
    localparam int maxCycles = 200;

    // Golden file columns
    localparam int colCsN    = 0;
    localparam int colWeN    = 1;
    localparam int colRefN   = 2;
    localparam int colBank   = 3;
    localparam int colAddr   = 4;
    localparam int colD      = 5;
    localparam int colDm     = 6;
    localparam int colQValid = 7;
    localparam int colQ      = 8;
    localparam int colTrc    = 9;
    localparam int colChkQ   = 10;

    logic    Ck;
    logic    rstN;
    logic    csN;
    logic    weN;
    logic    refN;
    rldAddrT addr;
    rldBankT bank;
    rldDataT d;
    logic    dm;
    rldDataT q;
    logic    qValid;
    logic    trcError;

    logic [`RLD_DATA_W-1:0] vecMem [numCols * maxLines];
    int numLines;
    int qValidErrs;
    int qErrs;
    int trcErrs;
    int otherErrs;

    rldTop i_rldTop (
        .Ck       (Ck),
        .rstN     (rstN),
        .csN      (csN),
        .weN      (weN),
        .refN     (refN),
        .addr     (addr),
        .bank     (bank),
        .d        (d),
        .dm       (dm),
        .q        (q),
        .qValid   (qValid),
        .trcError (trcError)
    );

    always #10 Ck = ~Ck;

    function automatic logic [`RLD_DATA_W-1:0] fieldAt(input int ln, input int col);
        return vecMem[ln * numCols + col];
    endfunction

    task automatic driveLine(input int ln);
        csN  = 1'(fieldAt(ln, colCsN));
        weN  = 1'(fieldAt(ln, colWeN));
        refN = 1'(fieldAt(ln, colRefN));
        bank = rldBankT'(fieldAt(ln, colBank));
        addr = rldAddrT'(fieldAt(ln, colAddr));
        d    = rldDataT'(fieldAt(ln, colD));
        dm   = 1'(fieldAt(ln, colDm));
    endtask

    task automatic checkOutputs(input int ln);
        logic    expValid;
        logic    expTrc;
        logic    chkQ;
        rldDataT expQ;
        expValid = 1'(fieldAt(ln, colQValid));
        expTrc   = 1'(fieldAt(ln, colTrc));
        chkQ     = 1'(fieldAt(ln, colChkQ));
        expQ     = rldDataT'(fieldAt(ln, colQ));
        assert (qValid === expValid) else begin
            qValidErrs++;
            $display("[ERROR] %0t qValid: expected %0b, got %0b (line %0d)",
                     $time, expValid, qValid, ln);
        end
        if (chkQ) begin
            assert (q === expQ) else begin
                qErrs++;
                $display("[ERROR] %0t q: expected %05h, got %05h (line %0d)",
                         $time, expQ, q, ln);
            end
        end
        assert (trcError === expTrc) else begin
            trcErrs++;
            $display("[ERROR] %0t trcError: expected %0b, got %0b (line %0d)",
                     $time, expTrc, trcError, ln);
        end
    endtask

    initial begin
        int ln;
        int cycles;
        Ck         = 1'b0;
        rstN       = 1'b0;
        csN        = 1'b1;
        weN        = 1'b1;
        refN       = 1'b1;
        bank       = '0;
        addr       = '0;
        d          = '0;
        dm         = 1'b0;
        qValidErrs = 0;
        qErrs      = 0;
        trcErrs    = 0;
        otherErrs  = 0;
        $readmemh("tb/rldGolden.txt", vecMem);
        // Vector count is the first line whose csN column was never loaded
        numLines = 0;
        while ((numLines < maxLines) && !$isunknown(vecMem[numLines * numCols])) begin
            numLines++;
        end
        if (numLines == 0) begin
            otherErrs++;
            $display("No vectors were loaded from the golden file");
        end

        repeat (2) @(posedge Ck);
        #2;
        rstN   = 1'b1;
        ln     = 0;
        cycles = 0;
        while ((ln < numLines) && (cycles < maxCycles)) begin
            driveLine(ln);
            #17;
            checkOutputs(ln);
            @(posedge Ck);
            #2;
            ln++;
            cycles++;
        end
        if (ln < numLines) begin
            otherErrs++;
            $display("Replay timed out after %0d cycles with %0d of %0d lines done",
                     cycles, ln, numLines);
        end

        $display("Errors: qValid %0d, q %0d, trcError %0d, other %0d over %0d lines",
                 qValidErrs, qErrs, trcErrs, otherErrs, ln);
        if ((qValidErrs + qErrs + trcErrs + otherErrs) == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- tb/rldGolden.txt
// csN weN refN bank addr d dm | expected: qValid q trcError | checkQ (all hex)
// One line per clock cycle after reset; expected outputs are those seen during that cycle
// Config 1 BL 2: writes to bank 3 and bank 6, refresh and early read of bank 3
1 1 1 0 00 00000 0 0 00000 0 1
0 0 1 3 04 00000 0 0 00000 0 1
1 1 1 0 00 00000 0 0 00000 0 1
0 0 1 6 02 00000 0 0 00000 0 1
1 1 1 0 00 00000 0 0 00000 0 1
0 1 0 3 00 00000 0 0 00000 0 1
1 1 1 0 00 12345 0 0 00000 0 1
0 1 1 3 04 2abcd 0 0 00000 0 1
1 1 1 0 00 0f0f0 0 0 00000 1 1
0 1 1 6 02 30303 0 0 00000 0 1
// Refresh bank 6, read bank 3 two cycles later, bank 6 after tRC
1 1 1 0 00 00000 0 0 00000 0 1
0 1 0 6 00 00000 0 0 00000 0 1
1 1 1 0 00 00000 0 1 12345 0 1
0 1 1 3 04 00000 0 1 2abcd 0 1
1 1 1 0 00 00000 0 1 0f0f0 0 1
0 1 1 6 02 00000 0 1 30303 0 1
1 1 1 0 00 00000 0 0 00000 0 1
1 1 1 0 00 00000 0 0 00000 0 1
1 1 1 0 00 00000 0 1 12345 0 1
1 1 1 0 00 00000 0 1 2abcd 0 1
// MRS to config 3 BL 8, masked 8-word write to bank 3, then read back
0 0 0 0 13 00000 0 1 0f0f0 0 1
0 0 1 3 01 00000 0 1 30303 0 1
1 1 1 0 00 00000 0 0 00000 0 1
1 1 1 0 00 00000 0 0 00000 0 1
1 1 1 0 00 00000 0 0 00000 0 1
1 1 1 0 00 00000 0 0 00000 0 1
1 1 1 0 00 00000 0 0 00000 0 1
1 1 1 0 00 00000 0 0 00000 0 1
1 1 1 0 00 00000 0 0 00000 0 1
1 1 1 0 00 00000 0 0 00000 0 1
1 1 1 0 00 20008 0 0 00000 0 1
0 1 1 3 01 3ffff 1 0 00000 0 1
1 1 1 0 00 2000a 0 0 00000 0 1
1 1 1 0 00 2000b 0 0 00000 0 1
1 1 1 0 00 2000c 0 0 00000 0 1
1 1 1 0 00 2000d 0 0 00000 0 1
1 1 1 0 00 2000e 0 0 00000 0 1
1 1 1 0 00 2000f 0 0 00000 0 1
1 1 1 0 00 00000 0 0 00000 0 1
1 1 1 0 00 00000 0 0 00000 0 1
1 1 1 0 00 00000 0 1 20008 0 1
1 1 1 0 00 00000 0 1 2abcd 0 1
1 1 1 0 00 00000 0 1 2000a 0 1
1 1 1 0 00 00000 0 1 2000b 0 1
1 1 1 0 00 00000 0 1 2000c 0 1
1 1 1 0 00 00000 0 1 2000d 0 1
1 1 1 0 00 00000 0 1 2000e 0 1
1 1 1 0 00 00000 0 1 2000f 0 1
1 1 1 0 00 00000 0 0 00000 0 1

//--- list.f
+incdir+include
hdl/rldCmdPkg.sv
hdl/rldDataPkg.sv
hdl/rldIfs.sv
hdl/rldCmdCheck.sv
hdl/rldModeReg.sv
hdl/rldLatencyPipe.sv
hdl/rldBurstEngine.sv
hdl/rldBankArray.sv
hdl/rldTop.sv
tb/rldTb.sv
